//--- alu_cfg.svh
// ----------------------------------------
// Width and bound settings for the ALU and
// its polar unit, included wherever needed
// ----------------------------------------

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// ----------------------------------------
// Scalar data path
// ----------------------------------------

// Full register width
`define ALU_XLEN 64

// Width of the W operations
`define ALU_WORD 32

// ----------------------------------------
// Polar SIMD lanes
// ----------------------------------------

`define ALU_LANE_W 8
`define ALU_LANES 8

// Saturated lanes clamp to +/- this value
`define ALU_SAT_MAX 127

`endif

//--- alu_decode.sv
// ----------------------------------------
// Operator decode into the control fields
// used by the execute and result stages
// ----------------------------------------

module alu_decode import alu_pkg::*; (
    input  alu_op_e   op_i,
    output alu_ctrl_t ctrl_o
);

    always_comb begin
        // Defaults give a zero result with no branch
        ctrl_o = '{
            negate_b:    1'b0,
            signed_cmp:  1'b0,
            shift_left:  1'b0,
            shift_arith: 1'b0,
            shift_word:  1'b0,
            logic_fn:    AND_FN,
            branch_fn:   BR_NONE,
            res_sel:     NONE,
            polar_fn:    P_R
        };

        unique case (op_i)
            // Adder
            ADD: ctrl_o.res_sel = ADDER;
            SUB: begin
                ctrl_o.negate_b = 1'b1;
                ctrl_o.res_sel  = ADDER;
            end
            ADDW: ctrl_o.res_sel = ADDER_W;
            SUBW: begin
                ctrl_o.negate_b = 1'b1;
                ctrl_o.res_sel  = ADDER_W;
            end

            // Logic operations and their negated forms
            ANDL, ANDN: begin
                ctrl_o.negate_b = (op_i == ANDN);
                ctrl_o.res_sel  = LOGIC;
            end
            ORL, ORN: begin
                ctrl_o.negate_b = (op_i == ORN);
                ctrl_o.logic_fn = OR_FN;
                ctrl_o.res_sel  = LOGIC;
            end
            XORL, XNOR: begin
                ctrl_o.negate_b = (op_i == XNOR);
                ctrl_o.logic_fn = XOR_FN;
                ctrl_o.res_sel  = LOGIC;
            end

            // Shifts
            SLL, SRL, SRA, SLLW, SRLW, SRAW: begin
                ctrl_o.shift_left  = (op_i == SLL) || (op_i == SLLW);
                ctrl_o.shift_arith = (op_i == SRA) || (op_i == SRAW);
                ctrl_o.shift_word  = (op_i == SLLW) || (op_i == SRLW) || (op_i == SRAW);
                ctrl_o.res_sel     = ctrl_o.shift_word ? SHIFT_W : SHIFT;
            end

            // Set less than
            SLTS, SLTU: begin
                ctrl_o.signed_cmp = (op_i == SLTS);
                ctrl_o.res_sel    = SLT;
            end

            // Branches compare through the adder and comparator
            EQ, NE: begin
                ctrl_o.negate_b  = 1'b1;
                ctrl_o.branch_fn = (op_i == EQ) ? BR_EQ : BR_NE;
            end
            LTS, LTU, GES, GEU: begin
                ctrl_o.signed_cmp = (op_i == LTS) || (op_i == GES);
                ctrl_o.branch_fn  = ((op_i == LTS) || (op_i == LTU)) ? BR_LT : BR_GE;
            end

            // Polar lanes
            PL_R, PL_F, PL_DECODE, PL_EVAL, PL_G: begin
                ctrl_o.res_sel = POLAR;
                unique case (op_i)
                    PL_F:      ctrl_o.polar_fn = P_F;
                    PL_DECODE: ctrl_o.polar_fn = P_DECODE;
                    PL_EVAL:   ctrl_o.polar_fn = P_EVAL;
                    PL_G:      ctrl_o.polar_fn = P_G;
                    default:   ctrl_o.polar_fn = P_R;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- alu_int_exec.sv
// ----------------------------------------
// Scalar execute: adder, comparator, logic
// unit and shifters, all combinational
// ----------------------------------------

`include "alu_cfg.svh"

module alu_int_exec import alu_pkg::*; (
    input  fu_data_t  fu_data_i,
    input  alu_ctrl_t ctrl_i,
    output int_res_t  int_res_o
);

    logic [`ALU_XLEN-1:0] op_a;
    logic [`ALU_XLEN-1:0] op_b;
    logic [`ALU_XLEN-1:0] op_b_neg;

    assign op_a = fu_data_i.operand_a;
    assign op_b = fu_data_i.operand_b;

    // ----------------------------------------
    // Adder and logic unit
    // ----------------------------------------

    // Ones' complement of b, carry-in completes the negation
    assign op_b_neg = ctrl_i.negate_b ? ~op_b : op_b;

    assign int_res_o.sum  = op_a + op_b_neg + {{(`ALU_XLEN-1){1'b0}}, ctrl_i.negate_b};
    assign int_res_o.zero = ~|int_res_o.sum;

    always_comb begin
        unique case (ctrl_i.logic_fn)
            OR_FN:   int_res_o.logic_res = op_a | op_b_neg;
            XOR_FN:  int_res_o.logic_res = op_a ^ op_b_neg;
            default: int_res_o.logic_res = op_a & op_b_neg;
        endcase
    end

    // Extra top bit carries the sign only for signed compares
    assign int_res_o.less =
        $signed({ctrl_i.signed_cmp & op_a[`ALU_XLEN-1], op_a}) <
        $signed({ctrl_i.signed_cmp & op_b[`ALU_XLEN-1], op_b});

    // ----------------------------------------
    // Shifters
    // ----------------------------------------

    // Left shifts run through the right shifter on reversed bits
    logic [`ALU_XLEN-1:0] a_rev;
    logic [`ALU_XLEN-1:0] sh_in;
    logic [`ALU_XLEN:0]   sh_ext;
    logic [`ALU_XLEN:0]   sh_right;
    logic [`ALU_XLEN-1:0] sh_out;
    logic [`ALU_XLEN-1:0] sh_out_rev;

    assign a_rev      = {<<{op_a}};
    assign sh_in      = ctrl_i.shift_left ? a_rev : op_a;
    assign sh_ext     = {ctrl_i.shift_arith & sh_in[`ALU_XLEN-1], sh_in};
    assign sh_right   = $unsigned($signed(sh_ext) >>> op_b[5:0]);
    assign sh_out     = sh_right[`ALU_XLEN-1:0];
    assign sh_out_rev = {<<{sh_out}};

    assign int_res_o.shift_res = ctrl_i.shift_left ? sh_out_rev : sh_out;

    // Word shifter only toggles for W shifts
    logic [`ALU_WORD-1:0] w_a;
    logic [`ALU_WORD-1:0] w_a_rev;
    logic [`ALU_WORD-1:0] w_in;
    logic [`ALU_WORD:0]   w_ext;
    logic [`ALU_WORD:0]   w_right;
    logic [`ALU_WORD-1:0] w_out;
    logic [`ALU_WORD-1:0] w_out_rev;

    assign w_a       = ctrl_i.shift_word ? op_a[`ALU_WORD-1:0] : '0;
    assign w_a_rev   = {<<{w_a}};
    assign w_in      = ctrl_i.shift_left ? w_a_rev : w_a;
    assign w_ext     = {ctrl_i.shift_arith & w_in[`ALU_WORD-1], w_in};
    assign w_right   = $unsigned($signed(w_ext) >>> op_b[4:0]);
    assign w_out     = w_right[`ALU_WORD-1:0];
    assign w_out_rev = {<<{w_out}};

    assign int_res_o.shift_res_w = ctrl_i.shift_left ? w_out_rev : w_out;

endmodule

//--- alu_pkg.sv
// ----------------------------------------
// Shared types of the ALU: operators, decoded
// control, issued operation and candidates
// ----------------------------------------

`include "alu_cfg.svh"

package alu_pkg;

    // Every operator the ALU executes
    typedef enum logic [5:0] {
        ADD, SUB, ADDW, SUBW,
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        SLTS, SLTU,
        EQ, NE, LTS, LTU, GES, GEU,
        PL_R, PL_F, PL_DECODE, PL_EVAL, PL_G
    } alu_op_e;

    // One issued operation
    typedef struct packed {
        alu_op_e             operator;
        logic [`ALU_XLEN-1:0] operand_a;
        logic [`ALU_XLEN-1:0] operand_b;
        logic [`ALU_XLEN-1:0] imm;
    } fu_data_t;

    // ----------------------------------------
    // Decoded control fields
    // ----------------------------------------

    typedef enum logic [2:0] {
        ADDER, ADDER_W, LOGIC, SHIFT, SHIFT_W, SLT, POLAR, NONE
    } res_sel_e;

    typedef enum logic [1:0] {AND_FN, OR_FN, XOR_FN} logic_fn_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} branch_fn_e;

    typedef enum logic [2:0] {P_R, P_F, P_DECODE, P_EVAL, P_G} polar_fn_e;

    typedef struct packed {
        logic       negate_b;
        logic       signed_cmp;
        logic       shift_left;
        logic       shift_arith;
        logic       shift_word;
        logic_fn_e  logic_fn;
        branch_fn_e branch_fn;
        res_sel_e   res_sel;
        polar_fn_e  polar_fn;
    } alu_ctrl_t;

    // Scalar candidates and flags
    typedef struct packed {
        logic [`ALU_XLEN-1:0] sum;
        logic [`ALU_XLEN-1:0] logic_res;
        logic [`ALU_XLEN-1:0] shift_res;
        logic [`ALU_WORD-1:0] shift_res_w;
        logic                 less;
        logic                 zero;
    } int_res_t;

endpackage

//--- alu_polar_exec.sv
// ----------------------------------------
// Polar SIMD execute on signed byte lanes,
// combinational, one function per operation
// ----------------------------------------

`include "alu_cfg.svh"

module alu_polar_exec import alu_pkg::*; (
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    input  logic [`ALU_XLEN-1:0] imm_i,
    input  polar_fn_e            polar_fn_i,
    output logic [`ALU_XLEN-1:0] polar_res_o
);

    // Clamp a widened lane value to +/- the saturation bound
    function automatic logic [`ALU_LANE_W-1:0] sat_lane(input logic signed [`ALU_LANE_W:0] v);
        logic [`ALU_LANE_W-1:0] res;
        if (v > `ALU_SAT_MAX)
            res = `ALU_SAT_MAX;
        else if (v < -`ALU_SAT_MAX)
            res = -`ALU_SAT_MAX;
        else
            res = v[`ALU_LANE_W-1:0];
        return res;
    endfunction

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        logic signed [`ALU_LANE_W-1:0] a;
        logic signed [`ALU_LANE_W-1:0] b;
        logic [`ALU_LANE_W-1:0]        m;
        logic [`ALU_LANE_W-1:0]        abs_a;
        logic [`ALU_LANE_W-1:0]        abs_b;
        logic [`ALU_LANE_W-1:0]        mag;
        logic                          flip;
        logic signed [`ALU_LANE_W:0]   add_w;
        logic signed [`ALU_LANE_W:0]   sub_w;
        logic [`ALU_LANE_W-1:0]        lane_res;

        assign a = operand_a_i[i*`ALU_LANE_W +: `ALU_LANE_W];
        assign b = operand_b_i[i*`ALU_LANE_W +: `ALU_LANE_W];
        assign m = imm_i[i*`ALU_LANE_W +: `ALU_LANE_W];

        // Magnitudes wrap for -128, as an 8-bit negation does
        assign abs_a = a[`ALU_LANE_W-1] ? -a : a;
        assign abs_b = b[`ALU_LANE_W-1] ? -b : b;
        assign mag   = (abs_a < abs_b) ? abs_a : abs_b;
        assign flip  = a[`ALU_LANE_W-1] ^ b[`ALU_LANE_W-1];

        // One extra bit holds the overflow before clamping
        assign add_w = a + b;
        assign sub_w = b - a;

        always_comb begin
            unique case (polar_fn_i)
                P_R:      lane_res = {{(`ALU_LANE_W-1){1'b0}}, (b != 1) && a[`ALU_LANE_W-1]};
                P_F:      lane_res = flip ? -mag : mag;
                P_DECODE: lane_res = (b == 0) ? a : '0;
                P_EVAL:   lane_res = (a == 1) ? '1 : '0;
                P_G:      lane_res = (m == '0) ? sat_lane(add_w) : sat_lane(sub_w);
                default:  lane_res = '0;
            endcase
        end

        assign polar_res_o[i*`ALU_LANE_W +: `ALU_LANE_W] = lane_res;
    end

endmodule

//--- alu_props.sv
// ----------------------------------------
// Output protocol assertions, bound onto
// the ALU top level
// ----------------------------------------

`include "alu_cfg.svh"

module alu_props (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 valid_i,
    input logic [`ALU_XLEN-1:0] result_o,
    input logic                 valid_o
);

    // Output stage leaves reset idle
    a_reset_idle: assert property (@(posedge clk_i) $past(reset_i) |-> !valid_o)
        else $error("valid_o high in the cycle after reset");

    // Exactly one cycle from valid_i to valid_o
    a_valid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> (valid_o == $past(valid_i)))
        else $error("valid_o does not follow valid_i by one cycle");

    a_result_known: assert property (@(posedge clk_i) valid_o |-> !$isunknown(result_o))
        else $error("result_o has unknown bits while valid_o is high");

endmodule

bind alu_top alu_props u_alu_props (.*);

//--- alu_result.sv
// ----------------------------------------
// Candidate and branch select, then the
// output register with its valid strobe
// ----------------------------------------

`include "alu_cfg.svh"

module alu_result import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  alu_ctrl_t            ctrl_i,
    input  int_res_t             int_res_i,
    input  logic [`ALU_XLEN-1:0] polar_res_i,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_res_o,
    output logic                 valid_o
);

    localparam int EXT_W = `ALU_XLEN - `ALU_WORD;

    logic [`ALU_XLEN-1:0] result_d;
    logic                 branch_d;

    always_comb begin
        unique case (ctrl_i.res_sel)
            ADDER:   result_d = int_res_i.sum;
            ADDER_W: result_d = {{EXT_W{int_res_i.sum[`ALU_WORD-1]}},
                                 int_res_i.sum[`ALU_WORD-1:0]};
            LOGIC:   result_d = int_res_i.logic_res;
            SHIFT:   result_d = int_res_i.shift_res;
            SHIFT_W: result_d = {{EXT_W{int_res_i.shift_res_w[`ALU_WORD-1]}},
                                 int_res_i.shift_res_w};
            SLT:     result_d = {{(`ALU_XLEN-1){1'b0}}, int_res_i.less};
            POLAR:   result_d = polar_res_i;
            default: result_d = '0;
        endcase
    end

    // Non-branch operations report taken
    always_comb begin
        unique case (ctrl_i.branch_fn)
            BR_EQ:   branch_d = int_res_i.zero;
            BR_NE:   branch_d = ~int_res_i.zero;
            BR_LT:   branch_d = int_res_i.less;
            BR_GE:   branch_d = ~int_res_i.less;
            default: branch_d = 1'b1;
        endcase
    end

    // ----------------------------------------
    // Output stage, one cycle of latency
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_o     <= '0;
            branch_res_o <= 1'b0;
            valid_o      <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // Hold the last result while idle
            if (valid_i) begin
                result_o     <= result_d;
                branch_res_o <= branch_d;
            end
        end
    end

endmodule

//--- alu_top.sv
// ----------------------------------------
// ALU top level: decode, scalar and polar
// execute, registered result stage
// ----------------------------------------

`include "alu_cfg.svh"

module alu_top import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  fu_data_t             fu_data_i,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_res_o,
    output logic                 valid_o
);

    alu_ctrl_t            ctrl;
    int_res_t             int_res;
    logic [`ALU_XLEN-1:0] polar_res;

    alu_decode u_alu_decode (
        .op_i   (fu_data_i.operator),
        .ctrl_o (ctrl)
    );

    alu_int_exec u_alu_int_exec (
        .fu_data_i (fu_data_i),
        .ctrl_i    (ctrl),
        .int_res_o (int_res)
    );

    alu_polar_exec u_alu_polar_exec (
        .operand_a_i (fu_data_i.operand_a),
        .operand_b_i (fu_data_i.operand_b),
        .imm_i       (fu_data_i.imm),
        .polar_fn_i  (ctrl.polar_fn),
        .polar_res_o (polar_res)
    );

    alu_result u_alu_result (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .ctrl_i       (ctrl),
        .int_res_i    (int_res),
        .polar_res_i  (polar_res),
        .result_o     (result_o),
        .branch_res_o (branch_res_o),
        .valid_o      (valid_o)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu -f sim.f

rc=0
./obj_dir/Vtb_alu > sim.log 2>&1 || rc=$?
cat sim.log
if [ "$rc" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

//--- sim.f
+incdir+.
alu_pkg.sv
alu_decode.sv
alu_int_exec.sv
alu_polar_exec.sv
alu_result.sv
alu_top.sv
alu_props.sv
tb_alu.sv

//--- tb_alu.sv
// ----------------------------------------
// Table-driven testbench for the ALU top
// level that issues rows back to back
// ----------------------------------------

`include "alu_cfg.svh"

module tb_alu import alu_pkg::*; ();

    typedef logic [`ALU_XLEN-1:0] word_t;

    // Issued operation with its expected outputs
    typedef struct packed {
        fu_data_t op_data;
        word_t    exp_res;
        logic     exp_br;
    } row_t;

    localparam int WAIT_LIMIT = 10;

    logic     clk_i;
    logic     reset_i;
    logic     valid_i;
    fu_data_t fu_data_i;
    word_t    result_o;
    logic     branch_res_o;
    logic     valid_o;

    row_t        rows[$];
    logic [31:0] lfsr_state;
    int          result_errors;
    int          branch_errors;
    int          valid_errors;

    alu_top u_alu_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[`ALU_XLEN-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ----------------------------------------
    // Reference model of one polar lane
    // ----------------------------------------

    function automatic logic [7:0] polar_lane(input alu_op_e op, input logic [7:0] a, b, m);
        logic [7:0]        mag_a;
        logic [7:0]        mag_b;
        logic [7:0]        keep;
        logic signed [9:0] s;
        mag_a = a[7] ? ~a + 8'd1 : a;
        mag_b = b[7] ? ~b + 8'd1 : b;
        keep  = (mag_a < mag_b) ? mag_a : mag_b;
        if (m == 8'd0)
            s = $signed({{2{a[7]}}, a}) + $signed({{2{b[7]}}, b});
        else
            s = $signed({{2{b[7]}}, b}) - $signed({{2{a[7]}}, a});
        case (op)
            PL_R:      return (b == 8'd1) ? 8'd0 : {7'd0, a[7]};
            PL_F:      return (a[7] ^ b[7]) ? ~keep + 8'd1 : keep;
            PL_DECODE: return (b == 8'd0) ? a : 8'd0;
            PL_EVAL:   return (a == 8'd1) ? 8'hFF : 8'd0;
            default:   return (s > 10'sd127) ? 8'h7F : (s < -10'sd127) ? 8'h81 : s[7:0];
        endcase
    endfunction

    function automatic word_t polar_word(input alu_op_e op, input word_t a, b, m);
        word_t res;
        for (int k = 0; k < `ALU_LANES; k++)
            res[k*8 +: 8] = polar_lane(op, a[k*8 +: 8], b[k*8 +: 8], m[k*8 +: 8]);
        return res;
    endfunction

    function automatic void add_row(input alu_op_e op, input word_t a, b, m, res,
                                    input logic br);
        rows.push_back('{op_data: '{operator: op, operand_a: a, operand_b: b, imm: m},
                         exp_res: res, exp_br: br});
    endfunction

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    function automatic void build_table();
        word_t   la;
        word_t   lb;
        word_t   sa;
        word_t   wa;
        word_t   nm;
        word_t   a;
        word_t   b;
        word_t   m;
        logic    lt_s;
        logic    lt_u;
        alu_op_e op;
        la = 64'hF0F0_F0F0_0F0F_0F0F;
        lb = 64'hFF00_FF00_FF00_FF00;
        sa = 64'h8000_0000_0000_0001;
        wa = 64'h0000_0000_8000_0010;
        nm = '1;
        // Word forms sign-extend from bit 31
        add_row(ADD, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, '0, 64'h8000_0000_0000_0000, 1'b1);
        add_row(SUB, 64'd5, 64'd7, '0, 64'hFFFF_FFFF_FFFF_FFFE, 1'b1);
        add_row(ADDW, 64'h0000_0000_7FFF_FFFF, 64'd1, '0, 64'hFFFF_FFFF_8000_0000, 1'b1);
        add_row(SUBW, 64'h1234_5678_0000_0000, 64'd1, '0, nm, 1'b1);
        add_row(ANDL, la, lb, '0, 64'hF000_F000_0F00_0F00, 1'b1);
        add_row(ORL,  la, lb, '0, 64'hFFF0_FFF0_FF0F_FF0F, 1'b1);
        add_row(XORL, la, lb, '0, 64'h0FF0_0FF0_F00F_F00F, 1'b1);
        add_row(ANDN, la, lb, '0, 64'h00F0_00F0_000F_000F, 1'b1);
        add_row(ORN,  la, lb, '0, 64'hF0FF_F0FF_0FFF_0FFF, 1'b1);
        add_row(XNOR, la, lb, '0, 64'hF00F_F00F_0FF0_0FF0, 1'b1);
        add_row(SLL, sa, 64'd0,  '0, sa, 1'b1);
        add_row(SLL, sa, 64'd1,  '0, 64'h0000_0000_0000_0002, 1'b1);
        add_row(SLL, sa, 64'd63, '0, 64'h8000_0000_0000_0000, 1'b1);
        add_row(SRL, sa, 64'd0,  '0, sa, 1'b1);
        add_row(SRL, sa, 64'd1,  '0, 64'h4000_0000_0000_0000, 1'b1);
        add_row(SRL, sa, 64'd63, '0, 64'h0000_0000_0000_0001, 1'b1);
        add_row(SRA, sa, 64'd0,  '0, sa, 1'b1);
        add_row(SRA, sa, 64'd1,  '0, 64'hC000_0000_0000_0000, 1'b1);
        add_row(SRA, sa, 64'd63, '0, nm, 1'b1);
        add_row(SLLW, 64'hFFFF_FFFF_0800_0001, 64'd4, '0, 64'hFFFF_FFFF_8000_0010, 1'b1);
        add_row(SRLW, wa, 64'd4, '0, 64'h0000_0000_0800_0001, 1'b1);
        add_row(SRAW, wa, 64'd4, '0, 64'hFFFF_FFFF_F800_0001, 1'b1);
        // Equal, then -1 against 1 both ways round
        for (int p = 0; p < 3; p++) begin
            a    = (p == 0) ? 64'd5 : (p == 1) ? nm : 64'd1;
            b    = (p == 0) ? 64'd5 : (p == 1) ? 64'd1 : nm;
            lt_s = $signed(a) < $signed(b);
            lt_u = a < b;
            add_row(SLTS, a, b, '0, word_t'(lt_s), 1'b1);
            add_row(SLTU, a, b, '0, word_t'(lt_u), 1'b1);
            add_row(EQ,  a, b, '0, '0, a == b);
            add_row(NE,  a, b, '0, '0, a != b);
            add_row(LTS, a, b, '0, '0, lt_s);
            add_row(LTU, a, b, '0, '0, lt_u);
            add_row(GES, a, b, '0, '0, !lt_s);
            add_row(GEU, a, b, '0, '0, !lt_u);
        end
        // Boundary lanes 0, 1, -1, 127 and -128
        a = 64'h0001_FF7F_807F_80FF;
        b = 64'h0100_FF01_FF80_7F01;
        for (int k = 0; k < 5; k++) begin
            op = alu_op_e'(int'(PL_R) + k);
            add_row(op, a, b, '0, polar_word(op, a, b, '0), 1'b1);
        end
        add_row(PL_G, a, b, lb, polar_word(PL_G, a, b, lb), 1'b1);
        for (int k = 0; k < 12; k++) begin
            a = rand_bits(64);
            b = rand_bits(64);
            m = rand_bits(64) & 64'hFF00_00FF_00FF_FF00;
            case (k % 4)
                0: add_row(ADD, a, b, m, a + b, 1'b1);
                1: add_row(SUB, a, b, m, a - b, 1'b1);
                2: add_row(PL_F, a, b, m, polar_word(PL_F, a, b, m), 1'b1);
                default: add_row(PL_G, a, b, m, polar_word(PL_G, a, b, m), 1'b1);
            endcase
        end
    endfunction

    // ----------------------------------------
    // Checks and waits
    // ----------------------------------------

    task automatic check_result(input string tag, input word_t got, input word_t exp);
        if (got !== exp) begin
            result_errors++;
            $display("ERROR result_o %s: got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic check_branch(input string tag, input logic got, input logic exp);
        if (got !== exp) begin
            branch_errors++;
            $display("ERROR branch_res_o %s: got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic check_valid(input string tag, input logic got, input logic exp);
        if (got !== exp) begin
            valid_errors++;
            $display("ERROR valid_o %s: got %h expected %h", tag, got, exp);
        end
    endtask

    // Result is due one edge after issue
    task automatic wait_valid();
        int edges;
        edges = 0;
        @(posedge clk_i);
        #1;
        while (valid_o !== 1'b1 && edges < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            edges++;
        end
        if (valid_o !== 1'b1) begin
            $display("Timed out after %0d cycles waiting for valid_o", WAIT_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end else if (edges != 0) begin
            valid_errors++;
            $display("valid_o came %0d cycles later than one cycle after issue", edges);
        end
    endtask

    initial begin
        string   tag;
        alu_op_e op;
        reset_i       = 1'b1;
        valid_i       = 1'b0;
        fu_data_i     = '0;
        lfsr_state    = 32'h3b989c5e;
        result_errors = 0;
        branch_errors = 0;
        valid_errors  = 0;
        build_table();
        repeat (2) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        check_valid("after reset", valid_o, 1'b0);
        check_result("after reset", result_o, '0);
        check_branch("after reset", branch_res_o, 1'b0);

        // Back-to-back issue of one row per cycle
        foreach (rows[i]) begin
            valid_i   = 1'b1;
            fu_data_i = rows[i].op_data;
            wait_valid();
            op  = rows[i].op_data.operator;
            tag = $sformatf("row %0d %s", i, op.name());
            check_result(tag, result_o, rows[i].exp_res);
            check_branch(tag, branch_res_o, rows[i].exp_br);
            #1;
        end

        // Outputs hold through an idle cycle with a not-taken EQ on the bus
        valid_i             = 1'b0;
        fu_data_i.operator  = EQ;
        fu_data_i.operand_a = rand_bits(64);
        @(posedge clk_i);
        #1;
        check_valid("idle cycle", valid_o, 1'b0);
        check_result("idle hold", result_o, rows[$].exp_res);
        check_branch("idle hold", branch_res_o, rows[$].exp_br);

        $display("Errors: result %0d, branch %0d, valid %0d",
                 result_errors, branch_errors, valid_errors);
        if (result_errors + branch_errors + valid_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
